//--- testbench/memtest_stim.txt
# columns in hex: mode seed base words fault_adr fault_mask
# mode 0 ones, 1 addr, 2 inverted addr, 3 addr xor seed; mask 0 means no fault
0 00000000 000100 0010 000000 00000000
1 00000000 000200 0014 000000 00000000
2 00000000 000300 000c 000000 00000000
3 a5a5a5a5 001000 0018 000000 00000000
1 00000000 000400 0010 000407 00010000
3 12345678 000500 0010 000600 ffffffff
2 00000000 000700 0000 000700 00000001
0 00000000 00fff8 0008 00fffc 80000000
3 0f0f0f0f fffff0 0010 000000 00000000
2 00000000 002000 0020 00201f 0000ff00
1 00000000 003000 0001 000000 00000000

//--- flist.f
+incdir+design
design/memtest_pkg.sv
design/wb_if.sv
design/pattern_writer.sv
design/readback_checker.sv
design/wb_arbiter.sv
design/memtest_top.sv
testbench/tb_clkgen.sv
testbench/memtest_sva.sv
testbench/memtest_monitor.sv
testbench/memtest_tb.sv

//--- Bender.yml
package:
  name: memtest

export_include_dirs:
  - design

sources:
  - include_dirs:
      - design
    files:
      - design/memtest_pkg.sv
      - design/wb_if.sv
      - design/pattern_writer.sv
      - design/readback_checker.sv
      - design/wb_arbiter.sv
      - design/memtest_top.sv
  - target: test
    include_dirs:
      - design
    files:
      - testbench/tb_clkgen.sv
      - testbench/memtest_sva.sv
      - testbench/memtest_monitor.sv
      - testbench/memtest_tb.sv

//--- testbench/memtest_tb.sv
`timescale 1ns/10ps
`include "memtest_settings.svh"

module memtest_tb;
  import memtest_pkg::*;

  logic                 clk;
  logic                 rst_n;
  logic                 start;
  logic [1:0]           pattern;
  data_t                seed;
  addr_t                base;
  cnt_t                 words;
  logic                 busy;
  logic                 done;
  logic                 pass;
  cnt_t                 err_count;
  addr_t                first_err;
  logic                 wb_cyc;
  logic                 wb_stb;
  logic                 wb_we;
  addr_t                wb_adr;
  data_t                wb_wdat;    // dut to memory
  logic [`MT_SEL_W-1:0] wb_sel;
  data_t                wb_rdat;    // memory to dut
  logic                 wb_ack;
  addr_t                fault_adr;  // read of this address gets corrupted
  data_t                fault_mask;
  data_t                mem [addr_t];
  logic                 in_xfer;
  int unsigned          wait_left;
  int unsigned          tests_run;
  int unsigned          checked;
  int unsigned          failed;

  tb_clkgen u_clkgen (
    .clk     (clk),
    .rst_n_o (rst_n)
  );

  memtest_top dut (
    .clk                (clk),
    .rst_n_i            (rst_n),
    .ctrl_start_i       (start),
    .ctrl_pattern_i     (pattern),
    .ctrl_seed_i        (seed),
    .ctrl_base_i        (base),
    .ctrl_words_i       (words),
    .status_busy_o      (busy),
    .status_done_o      (done),
    .status_pass_o      (pass),
    .status_err_count_o (err_count),
    .status_first_err_o (first_err),
    .wb_cyc_o           (wb_cyc),
    .wb_stb_o           (wb_stb),
    .wb_we_o            (wb_we),
    .wb_adr_o           (wb_adr),
    .wb_dat_o           (wb_wdat),
    .wb_sel_o           (wb_sel),
    .wb_dat_i           (wb_rdat),
    .wb_ack_i           (wb_ack)
  );

  memtest_monitor u_monitor (
    .clk (clk), .rst_n_i (rst_n),
    .ctrl_start_i (start), .ctrl_pattern_i (pattern), .ctrl_seed_i (seed),
    .ctrl_base_i (base), .ctrl_words_i (words),
    .fault_adr_i (fault_adr), .fault_mask_i (fault_mask),
    .status_busy_i (busy), .status_done_i (done), .status_pass_i (pass),
    .status_err_count_i (err_count), .status_first_err_i (first_err),
    .wb_cyc_i (wb_cyc), .wb_stb_i (wb_stb), .wb_we_i (wb_we), .wb_adr_i (wb_adr),
    .wb_wdat_i (wb_wdat), .wb_sel_i (wb_sel), .wb_ack_i (wb_ack),
    .checked_o (checked), .failed_o (failed)
  );

  bind memtest_top memtest_sva u_sva (
    .clk (clk), .rst_n_i (rst_n_i),
    .wb_cyc_i (wb_cyc_o), .wb_stb_i (wb_stb_o), .wb_we_i (wb_we_o), .wb_adr_i (wb_adr_o),
    .wb_wdat_i (wb_dat_o), .wb_sel_i (wb_sel_o), .wb_ack_i (wb_ack_i),
    .status_busy_i (status_busy_o), .status_done_i (status_done_o)
  );

  // stored word xor the fault mask at the fault address
  function automatic data_t read_word(addr_t a);
    data_t d;
    d = mem.exists(a) ? mem[a] : '0;
    if (a == fault_adr) d = d ^ fault_mask;
    return d;
  endfunction

  // memory model with 0..3 wait states per access and a single ack cycle
  initial begin
    wait_left = $urandom(32'he859c55e);  // seeds the wait-state picks of this process
    forever begin
      @(negedge clk);
      if (!rst_n) begin
        wb_ack  = 1'b0;
        in_xfer = 1'b0;
      end else if (wb_ack) begin
        wb_ack  = 1'b0;  // master drops cyc after its ack
        in_xfer = 1'b0;
      end else if (wb_cyc && wb_stb) begin
        if (!in_xfer) begin
          in_xfer   = 1'b1;
          wait_left = $urandom % 4;
        end
        if (wait_left == 0) begin
          if (wb_we) mem[wb_adr] = wb_wdat;
          else wb_rdat = read_word(wb_adr);
          wb_ack = 1'b1;
        end else begin
          wait_left--;
        end
      end
    end
  end

  task automatic wait_reset(output bit ok);
    int unsigned cycles;
    ok     = 1'b0;
    cycles = 0;
    while (!ok && cycles < 20) begin
      @(posedge clk);
      cycles++;
      if (rst_n) ok = 1'b1;
    end
    if (!ok) $display("reset was not released within 20 cycles");
  endtask

  // apply one row, pulse start and wait for done
  task automatic run_test(input logic [1:0] mode, input data_t sd, input addr_t b,
                          input cnt_t w, input addr_t fa, input data_t fm, output bit ok);
    int unsigned limit;
    int unsigned cycles;
    limit = 40 * w + 100;
    @(negedge clk);
    mem.delete();
    fault_adr  = fa;
    fault_mask = fm;
    pattern    = mode;
    seed       = sd;
    base       = b;
    words      = w;
    start      = 1'b1;
    tests_run++;
    @(negedge clk);
    start  = 1'b0;
    ok     = 1'b0;
    cycles = 0;
    while (!ok && cycles < limit) begin
      @(posedge clk);
      cycles++;
      if (done) ok = 1'b1;  // old done was cleared at the start edge
    end
    if (!ok) $display("test %0d got no done within %0d cycles", tests_run, limit);
  endtask

  initial begin
    int          fd;
    int          n;
    string       line;
    logic [31:0] r_mode;
    logic [31:0] r_seed;
    logic [31:0] r_base;
    logic [31:0] r_words;
    logic [31:0] r_fadr;
    logic [31:0] r_fmask;
    bit          ok;
    bit          aborted;
    int unsigned sva_fails;
    start      = 1'b0;
    pattern    = 2'd0;
    seed       = '0;
    base       = '0;
    words      = '0;
    wb_rdat    = '0;
    wb_ack     = 1'b0;
    fault_adr  = '0;
    fault_mask = '0;
    tests_run  = 0;
    aborted    = 1'b0;
    wait_reset(ok);
    if (!ok) aborted = 1'b1;
    fd = $fopen("testbench/memtest_stim.txt", "r");
    if (fd == 0) begin
      $display("cannot open testbench/memtest_stim.txt");
      aborted = 1'b1;
    end else begin
      while (!aborted && !$feof(fd)) begin
        line = "";
        n = $fgets(line, fd);
        if (n > 0 && line.getc(0) != "#") begin  // skip column notes
          n = $sscanf(line, "%h %h %h %h %h %h", r_mode, r_seed, r_base, r_words,
                      r_fadr, r_fmask);
          if (n == 6) begin
            run_test(r_mode[1:0], r_seed, r_base[`MT_ADDR_W-1:0], r_words[`MT_CNT_W-1:0],
                     r_fadr[`MT_ADDR_W-1:0], r_fmask, ok);
            if (!ok) aborted = 1'b1;
          end
        end
      end
      $fclose(fd);
    end
    repeat (3) @(posedge clk);  // let the monitor close the last run
    sva_fails = dut.u_sva.fail_count;
    $display("tests run %0d, checked %0d, failed %0d, assertion failures %0d",
             tests_run, checked, failed, sva_fails);
    if (!aborted && tests_run > 0 && checked == tests_run && failed == 0 && sva_fails == 0) begin
      $display("STATUS: PASS");
    end else begin
      $display("STATUS: FAIL");
    end
    $finish;
  end

endmodule

//--- testbench/memtest_monitor.sv
`timescale 1ns/10ps
`include "memtest_settings.svh"

// watches the harness ports, predicts each run and compares
module memtest_monitor (
  input  logic                  clk,
  input  logic                  rst_n_i,
  input  logic                  ctrl_start_i,
  input  logic [1:0]            ctrl_pattern_i,
  input  memtest_pkg::data_t    ctrl_seed_i,
  input  memtest_pkg::addr_t    ctrl_base_i,
  input  memtest_pkg::cnt_t     ctrl_words_i,
  input  memtest_pkg::addr_t    fault_adr_i,    // from the stim row
  input  memtest_pkg::data_t    fault_mask_i,
  input  logic                  status_busy_i,
  input  logic                  status_done_i,
  input  logic                  status_pass_i,
  input  memtest_pkg::cnt_t     status_err_count_i,
  input  memtest_pkg::addr_t    status_first_err_i,
  input  logic                  wb_cyc_i,
  input  logic                  wb_stb_i,
  input  logic                  wb_we_i,
  input  memtest_pkg::addr_t    wb_adr_i,
  input  memtest_pkg::data_t    wb_wdat_i,
  input  logic [`MT_SEL_W-1:0]  wb_sel_i,
  input  logic                  wb_ack_i,
  output int unsigned           checked_o,
  output int unsigned           failed_o
);
  import memtest_pkg::*;

  logic        active;              // a run is in flight
  logic        done_q;              // done at the previous edge
  int unsigned cyc_cnt;             // edges since start was taken
  int unsigned test_num;
  int unsigned problems;            // issues in the current run
  int unsigned n_wr;
  int unsigned n_rd;
  int unsigned n_checked;
  int unsigned n_failed;
  logic [1:0]  t_mode;
  data_t       t_seed;
  addr_t       t_base;
  cnt_t        t_words;
  addr_t       t_fadr;
  data_t       t_fmask;
  bit          written [addr_t];    // addresses with an acked write

  assign checked_o = n_checked;
  assign failed_o  = n_failed;

  // the four data patterns over a zero extended address
  function automatic data_t expected_word(logic [1:0] mode, data_t sd, addr_t a);
    data_t wide;
    wide = {{(`MT_DATA_W-`MT_ADDR_W){1'b0}}, a};
    case (mode)
      2'd0:    expected_word = {`MT_DATA_W{1'b1}};
      2'd1:    expected_word = wide;
      2'd2:    expected_word = ~wide;
      default: expected_word = wide ^ sd;
    endcase
  endfunction

  function automatic bit in_region(addr_t a);
    addr_t off;
    off = a - t_base;  // wraps like the bus address
    return (off < addr_t'(t_words));
  endfunction

  task automatic value_error(input string sig, input logic [31:0] exp_v,
                             input logic [31:0] got_v);
    $display("ERROR %s exp 0x%0h got 0x%0h in test %0d", sig, exp_v, got_v, test_num);
    problems++;
  endtask

  task automatic note_problem(input string what);
    $display("test %0d: %s", test_num, what);
    problems++;
  endtask

  task automatic check_write();
    data_t exp_d;
    exp_d = expected_word(t_mode, t_seed, wb_adr_i);
    n_wr++;
    if (!in_region(wb_adr_i))
      note_problem($sformatf("write to 0x%0h lies outside the region", wb_adr_i));
    else if (written.exists(wb_adr_i))
      note_problem($sformatf("address 0x%0h written more than once", wb_adr_i));
    else
      written[wb_adr_i] = 1'b1;
    if (wb_wdat_i !== exp_d) value_error("wb_dat_o", exp_d, wb_wdat_i);
    if (wb_sel_i !== {`MT_SEL_W{1'b1}}) value_error("wb_sel_o", {`MT_SEL_W{1'b1}}, wb_sel_i);
  endtask

  task automatic check_read();
    n_rd++;
    // bus is serial, so the write ack must already be behind us
    if (!written.exists(wb_adr_i))
      note_problem($sformatf("read of 0x%0h before its write was acknowledged", wb_adr_i));
  endtask

  task automatic finish_test();
    bit   hit;
    cnt_t exp_err;
    logic exp_pass;
    hit      = (t_fmask != '0) && in_region(t_fadr);  // injected fault gets read
    exp_err  = hit ? cnt_t'(1) : cnt_t'(0);
    exp_pass = !hit;
    if (t_words == '0 && cyc_cnt != 2)
      note_problem($sformatf("done came %0d cycles after start, not 2", cyc_cnt));
    if (n_wr != t_words)
      note_problem($sformatf("%0d writes seen for %0d words", n_wr, t_words));
    if (n_rd != t_words)
      note_problem($sformatf("done rose after %0d reads of %0d words", n_rd, t_words));
    if (status_err_count_i !== exp_err)
      value_error("status_err_count_o", exp_err, status_err_count_i);
    if (status_pass_i !== exp_pass) value_error("status_pass_o", exp_pass, status_pass_i);
    if (hit && status_first_err_i !== t_fadr)
      value_error("status_first_err_o", t_fadr, status_first_err_i);
    n_checked++;
    if (problems == 0) begin
      $display("test %0d mode %0d words %0d: ok", test_num, t_mode, t_words);
    end else begin
      n_failed++;
      $display("test %0d mode %0d words %0d: failed with %0d problems",
               test_num, t_mode, t_words, problems);
    end
    active = 1'b0;
  endtask

  always @(posedge clk) begin
    if (!rst_n_i) begin
      active = 1'b0;
      done_q = 1'b0;
    end else begin
      if (ctrl_start_i && !status_busy_i) begin
        test_num++;                 // start taken at this edge
        active   = 1'b1;
        cyc_cnt  = 0;
        problems = 0;
        n_wr     = 0;
        n_rd     = 0;
        written.delete();
        t_mode   = ctrl_pattern_i;
        t_seed   = ctrl_seed_i;
        t_base   = ctrl_base_i;
        t_words  = ctrl_words_i;
        t_fadr   = fault_adr_i;
        t_fmask  = fault_mask_i;
      end else if (active) begin
        cyc_cnt++;
        if (cyc_cnt == 1 && status_busy_i !== 1'b1)
          note_problem("busy did not rise one cycle after start");
      end
      if (wb_cyc_i && wb_stb_i && wb_ack_i) begin
        if (!active) begin
          note_problem("bus transfer while no test is running");
          n_failed++;  // no test line counts this one
        end else if (wb_we_i) begin
          check_write();
        end else begin
          check_read();
        end
      end
      if (status_done_i && !done_q) begin
        if (!active) begin
          note_problem("done rose with no test running");
          n_failed++;
        end else begin
          finish_test();
        end
      end
      done_q = status_done_i;
    end
  end

endmodule

//--- testbench/memtest_sva.sv
`timescale 1ns/10ps
`include "memtest_settings.svh"

// protocol and status properties, bound onto memtest_top
module memtest_sva (
  input  logic                  clk,
  input  logic                  rst_n_i,
  input  logic                  wb_cyc_i,
  input  logic                  wb_stb_i,
  input  logic                  wb_we_i,
  input  memtest_pkg::addr_t    wb_adr_i,
  input  memtest_pkg::data_t    wb_wdat_i,
  input  logic [`MT_SEL_W-1:0]  wb_sel_i,
  input  logic                  wb_ack_i,
  input  logic                  status_busy_i,
  input  logic                  status_done_i
);

  int unsigned fail_count = 0;  // read by the testbench top
  logic        rst_seen_q;      // reset already held for one edge

  always @(posedge clk) rst_seen_q <= !rst_n_i;

  a_stb_cyc: assert property (@(posedge clk) disable iff (!rst_n_i)
    wb_stb_i |-> wb_cyc_i)
    else begin
      $error("wishbone stb high without cyc");
      fail_count++;
    end

  // classic handshake, request frozen until ack
  a_req_hold: assert property (@(posedge clk) disable iff (!rst_n_i)
    (wb_stb_i && !wb_ack_i) |=> (wb_stb_i && $stable(wb_we_i) && $stable(wb_adr_i)
                                 && $stable(wb_wdat_i) && $stable(wb_sel_i)))
    else begin
      $error("wishbone request changed or dropped before ack");
      fail_count++;
    end

  a_done_busy: assert property (@(posedge clk) disable iff (!rst_n_i)
    !(status_done_i && status_busy_i))
    else begin
      $error("done and busy high in the same cycle");
      fail_count++;
    end

  a_rst_idle: assert property (@(posedge clk)
    (!rst_n_i && rst_seen_q === 1'b1) |-> (!wb_cyc_i && !wb_stb_i))
    else begin
      $error("wishbone cyc or stb high during reset");
      fail_count++;
    end

endmodule

//--- testbench/tb_clkgen.sv
`timescale 1ns/10ps

// free running clock and power-on reset for the testbench
module tb_clkgen (
  output logic clk,
  output logic rst_n_o
);

  // 10 ns period
  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  initial begin
    rst_n_o = 1'b0;                // in reset from time 0
    repeat (4) @(posedge clk);
    @(negedge clk);
    rst_n_o = 1'b1;                // released away from the sampling edge
  end

endmodule

//--- design/memtest_top.sv
`timescale 1ns/10ps
`include "memtest_settings.svh"

// memory test harness, writer and checker on one wishbone port
module memtest_top (
  input  logic                  clk,
  input  logic                  rst_n_i,
  input  logic                  ctrl_start_i,
  input  logic [1:0]            ctrl_pattern_i,  // pattern_e encoding
  input  memtest_pkg::data_t    ctrl_seed_i,
  input  memtest_pkg::addr_t    ctrl_base_i,
  input  memtest_pkg::cnt_t     ctrl_words_i,
  output logic                  status_busy_o,
  output logic                  status_done_o,
  output logic                  status_pass_o,
  output memtest_pkg::cnt_t     status_err_count_o,
  output memtest_pkg::addr_t    status_first_err_o,
  output logic                  wb_cyc_o,
  output logic                  wb_stb_o,
  output logic                  wb_we_o,
  output memtest_pkg::addr_t    wb_adr_o,
  output memtest_pkg::data_t    wb_dat_o,
  output logic [`MT_SEL_W-1:0]  wb_sel_o,
  input  memtest_pkg::data_t    wb_dat_i,
  input  logic                  wb_ack_i
);
  import memtest_pkg::*;

  pattern_e cfg_pattern;  // run config, stable for the whole run
  data_t    cfg_seed;
  addr_t    cfg_base;
  cnt_t     cfg_words;
  logic     run;          // accepted start
  logic     chk_busy;
  cnt_t     wr_count;
  logic     wr_done;

  wb_if wr_bus ();
  wb_if rd_bus ();
  wb_if mem_bus ();

  assign run = ctrl_start_i && !chk_busy;  // ignored during a run

  always_ff @(posedge clk) begin
    if (run) begin
      cfg_pattern <= pattern_e'(ctrl_pattern_i);
      cfg_seed    <= ctrl_seed_i;
      cfg_base    <= ctrl_base_i;
      cfg_words   <= ctrl_words_i;
    end
  end

  pattern_writer u_writer (
    .clk        (clk),
    .rst_n_i    (rst_n_i),
    .start_i    (run),
    .pattern_i  (cfg_pattern),
    .seed_i     (cfg_seed),
    .base_i     (cfg_base),
    .words_i    (cfg_words),
    .bus        (wr_bus.master),
    .wr_count_o (wr_count),
    .wr_done_o  (wr_done)
  );

  readback_checker u_checker (
    .clk         (clk),
    .rst_n_i     (rst_n_i),
    .start_i     (run),
    .pattern_i   (cfg_pattern),
    .seed_i      (cfg_seed),
    .base_i      (cfg_base),
    .words_i     (cfg_words),
    .wr_count_i  (wr_count),
    .wr_done_i   (wr_done),
    .bus         (rd_bus.master),
    .busy_o      (chk_busy),
    .done_o      (status_done_o),
    .pass_o      (status_pass_o),
    .err_count_o (status_err_count_o),
    .first_err_o (status_first_err_o)
  );

  wb_arbiter u_arbiter (
    .clk     (clk),
    .rst_n_i (rst_n_i),
    .m0      (wr_bus.slave),
    .m1      (rd_bus.slave),
    .s       (mem_bus.master)
  );

  assign status_busy_o = chk_busy;

  // memory side out to plain ports
  assign wb_cyc_o      = mem_bus.cyc;
  assign wb_stb_o      = mem_bus.stb;
  assign wb_we_o       = mem_bus.we;
  assign wb_adr_o      = mem_bus.adr;
  assign wb_dat_o      = mem_bus.dat_w;
  assign wb_sel_o      = mem_bus.sel;
  assign mem_bus.dat_r = wb_dat_i;
  assign mem_bus.ack   = wb_ack_i;

endmodule

//--- design/wb_arbiter.sv
`timescale 1ns/10ps
`include "memtest_settings.svh"

// two masters onto one wishbone port
// grant is comb from requests, ownership is held for the whole cycle
module wb_arbiter (
  input  logic  clk,
  input  logic  rst_n_i,
  wb_if.slave   m0,  // writer
  wb_if.slave   m1,  // checker
  wb_if.master  s    // external memory
);

  logic [`MT_MASTERS-1:0] req;
  logic                   locked_q;  // a cycle was granted earlier
  logic                   owner_q;   // last granted master
  logic                   hold;      // owner still inside its cycle
  logic                   gnt;       // 0 m0, 1 m1

  assign req  = {m1.cyc, m0.cyc};
  assign hold = locked_q && req[owner_q];

  always_comb begin
    if (hold) begin
      gnt = owner_q;  // keep until owner drops cyc
    end else if (&req) begin
      gnt = ~owner_q;  // both asking, other one's turn
    end else begin
      gnt = req[1];  // single or no request
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n_i) begin
      locked_q <= 1'b0;
      owner_q  <= 1'b1;  // so m0 wins the first tie
    end else begin
      locked_q <= |req;
      if (!hold && |req) owner_q <= gnt;  // new cycle starts
    end
  end

  // owner fields to memory
  assign s.cyc   = gnt ? m1.cyc   : m0.cyc;
  assign s.stb   = gnt ? m1.stb   : m0.stb;
  assign s.we    = gnt ? m1.we    : m0.we;
  assign s.adr   = gnt ? m1.adr   : m0.adr;
  assign s.dat_w = gnt ? m1.dat_w : m0.dat_w;
  assign s.sel   = gnt ? m1.sel   : m0.sel;

  // ack only to owner, loser keeps holding its request
  assign m0.ack = s.ack && !gnt;
  assign m1.ack = s.ack && gnt;

  // read data goes to both
  assign m0.dat_r = s.dat_r;
  assign m1.dat_r = s.dat_r;

endmodule

//--- design/readback_checker.sv
`timescale 1ns/10ps
`include "memtest_settings.svh"

// reads every word behind the writer and compares with the pattern
// owns busy, done and the result fields
module readback_checker (
  input  logic                  clk,
  input  logic                  rst_n_i,
  input  logic                  start_i,
  input  memtest_pkg::pattern_e pattern_i,
  input  memtest_pkg::data_t    seed_i,
  input  memtest_pkg::addr_t    base_i,
  input  memtest_pkg::cnt_t     words_i,
  input  memtest_pkg::cnt_t     wr_count_i,  // words the writer got acked
  input  logic                  wr_done_i,
  wb_if.master                  bus,
  output logic                  busy_o,
  output logic                  done_o,
  output logic                  pass_o,
  output memtest_pkg::cnt_t     err_count_o,
  output memtest_pkg::addr_t    first_err_o
);
  import memtest_pkg::*;

  chk_state_e state_q;
  cnt_t       idx_q;        // word under test
  cnt_t       err_q;
  addr_t      first_err_q;
  addr_t      rd_adr;
  logic       ready;        // word idx already written
  logic       mismatch;
  logic       last;         // idx is the final word

  assign rd_adr   = base_i + addr_t'(idx_q);
  assign ready    = wr_done_i || (wr_count_i > idx_q);
  assign mismatch = (bus.dat_r != pattern_word(pattern_i, seed_i, rd_adr));
  assign last     = (cnt_t'(idx_q + cnt_t'(1)) == words_i);

  // read only, cyc drops in WAIT after each ack
  assign bus.cyc   = (state_q == CHK_REQ);
  assign bus.stb   = (state_q == CHK_REQ);
  assign bus.we    = 1'b0;
  assign bus.adr   = rd_adr;
  assign bus.dat_w = '0;  // unused on reads
  assign bus.sel   = {`MT_SEL_W{1'b1}};

  assign err_count_o = err_q;
  assign first_err_o = first_err_q;

  always_ff @(posedge clk) begin
    if (!rst_n_i) begin
      state_q     <= CHK_IDLE;
      idx_q       <= '0;
      err_q       <= '0;
      first_err_q <= '0;
      busy_o      <= 1'b0;
      done_o      <= 1'b0;
      pass_o      <= 1'b0;
    end else begin
      case (state_q)
        CHK_IDLE, CHK_DONE: begin
          if (start_i) begin
            state_q     <= CHK_WAIT;
            idx_q       <= '0;
            err_q       <= '0;
            first_err_q <= '0;
            busy_o      <= 1'b1;  // visible one cycle after start
            done_o      <= 1'b0;
            pass_o      <= 1'b0;
          end
        end
        CHK_WAIT: begin
          if (idx_q == words_i) begin
            // only reached with an empty region
            state_q <= CHK_DONE;
            busy_o  <= 1'b0;
            done_o  <= 1'b1;
            pass_o  <= (err_q == '0);
          end else if (ready) begin
            state_q <= CHK_REQ;
          end
        end
        CHK_REQ: begin
          if (bus.ack) begin
            if (mismatch) begin
              err_q <= err_q + cnt_t'(1);
              if (err_q == '0) first_err_q <= rd_adr;  // keep the first one
            end
            idx_q <= idx_q + cnt_t'(1);
            if (last) begin
              state_q <= CHK_DONE;  // done rises right after last ack
              busy_o  <= 1'b0;
              done_o  <= 1'b1;
              pass_o  <= (err_q == '0) && !mismatch;
            end else begin
              state_q <= CHK_WAIT;
            end
          end
        end
        default: begin
          state_q <= CHK_IDLE;
          busy_o  <= 1'b0;
        end
      endcase
    end
  end

endmodule

//--- design/pattern_writer.sv
`timescale 1ns/10ps
`include "memtest_settings.svh"

// fills base .. base+words-1 with the pattern, one write per word
module pattern_writer (
  input  logic                  clk,
  input  logic                  rst_n_i,
  input  logic                  start_i,    // run strobe from top
  input  memtest_pkg::pattern_e pattern_i,
  input  memtest_pkg::data_t    seed_i,
  input  memtest_pkg::addr_t    base_i,
  input  memtest_pkg::cnt_t     words_i,
  wb_if.master                  bus,
  output memtest_pkg::cnt_t     wr_count_o, // acked writes so far
  output logic                  wr_done_o
);
  import memtest_pkg::*;

  wr_state_e state_q;
  cnt_t      idx_q;      // next word to write, also the acked count
  addr_t     wr_adr;
  logic      have_word;  // idx still inside region
  logic      req;

  assign have_word = (idx_q != words_i);
  assign wr_adr    = base_i + addr_t'(idx_q);

  // request only while a word is left, covers words == 0
  assign req = (state_q == WR_REQ) && have_word;

  assign bus.cyc   = req;
  assign bus.stb   = req;
  assign bus.we    = 1'b1;
  assign bus.adr   = wr_adr;
  assign bus.dat_w = pattern_word(pattern_i, seed_i, wr_adr);
  assign bus.sel   = {`MT_SEL_W{1'b1}};  // full word writes only

  // idx only moves on ack, so it is the written count
  assign wr_count_o = idx_q;
  assign wr_done_o  = (state_q == WR_DONE);

  always_ff @(posedge clk) begin
    if (!rst_n_i) begin
      state_q <= WR_IDLE;
      idx_q   <= '0;
    end else begin
      case (state_q)
        WR_IDLE, WR_DONE: begin
          if (start_i) begin
            state_q <= WR_REQ;  // first request next cycle
            idx_q   <= '0;
          end
        end
        WR_REQ: begin
          if (!have_word) begin
            state_q <= WR_DONE;  // region finished
          end else if (bus.ack) begin
            idx_q   <= idx_q + cnt_t'(1);
            state_q <= WR_NEXT;  // drop cyc after ack
          end
        end
        WR_NEXT: begin
          state_q <= WR_REQ;  // REQ decides between next word and done
        end
        default: begin
          state_q <= WR_IDLE;
        end
      endcase
    end
  end

endmodule

//--- design/wb_if.sv
`timescale 1ns/10ps
`include "memtest_settings.svh"

// wishbone classic, one transfer per cycle, no bursts
interface wb_if;
  import memtest_pkg::*;

  logic                 cyc;    // bus cycle in progress
  logic                 stb;    // valid transfer, always with cyc here
  logic                 we;     // 1 write, 0 read
  addr_t                adr;    // word address
  data_t                dat_w;  // master to slave data
  data_t                dat_r;  // slave to master data
  logic [`MT_SEL_W-1:0] sel;    // byte lanes
  logic                 ack;    // transfer done

  // master side holds request fields until ack
  modport master (
    output cyc, stb, we, adr, dat_w, sel,
    input  dat_r, ack
  );

  // slave side, mirror of master
  modport slave (
    input  cyc, stb, we, adr, dat_w, sel,
    output dat_r, ack
  );

endinterface

//--- design/memtest_pkg.sv
`include "memtest_settings.svh"

package memtest_pkg;

  // widths with a meaning
  typedef logic [`MT_ADDR_W-1:0] addr_t;  // word address
  typedef logic [`MT_DATA_W-1:0] data_t;  // data word
  typedef logic [`MT_CNT_W-1:0]  cnt_t;   // words, progress, errors

  // pattern select, encoding matches ctrl_pattern_i
  typedef enum logic [1:0] {
    PAT_ONES     = 2'd0,  // every bit set
    PAT_ADDR     = 2'd1,  // word address as data
    PAT_INV_ADDR = 2'd2,  // inverted word address
    PAT_XOR_SEED = 2'd3   // address xor seed
  } pattern_e;

  // writer fsm
  typedef enum logic [1:0] {
    WR_IDLE = 2'd0,  // waiting for start
    WR_REQ  = 2'd1,  // write request held until ack
    WR_NEXT = 2'd2,  // cyc low for one cycle
    WR_DONE = 2'd3   // region written
  } wr_state_e;

  // checker fsm
  typedef enum logic [1:0] {
    CHK_IDLE = 2'd0,  // waiting for start
    CHK_WAIT = 2'd1,  // writer not far enough yet
    CHK_REQ  = 2'd2,  // read request held until ack
    CHK_DONE = 2'd3   // result valid
  } chk_state_e;

  // the one pattern rule, shared by writer and checker
  // address is zero extended to the data width before use
  function automatic data_t pattern_word(pattern_e mode, data_t seed, addr_t adr);
    data_t a;
    a = data_t'(adr);
    case (mode)
      PAT_ONES:     return '1;
      PAT_ADDR:     return a;
      PAT_INV_ADDR: return ~a;
      default:      return a ^ seed;  // PAT_XOR_SEED
    endcase
  endfunction

endpackage

//--- design/memtest_settings.svh
`ifndef MEMTEST_SETTINGS_SVH
`define MEMTEST_SETTINGS_SVH

// project-wide widths for the memory test harness

// word address into external memory
`define MT_ADDR_W   24
// one memory word
`define MT_DATA_W   32
// word count, progress and error count
`define MT_CNT_W    16
// byte lanes per word
`define MT_SEL_W    4

// masters sharing the memory port (writer, checker)
`define MT_MASTERS  2

`endif
